//--- include/spm_macros.svh
`ifndef SPM_MACROS_SVH
`define SPM_MACROS_SVH

// Scratchpad geometry shared by the package and the RTL

// Banks the word space is interleaved over, power of two
`define SPM_NUM_BANKS 4

// Word address bits inside one bank
`define SPM_BANK_AW 8

// Bytes in one data line
`define SPM_BYTES 4

// Bank-select bits, log2 of the bank count
`define SPM_SEL_W 2

`endif

//--- verilog/spm_pkg.sv
`include "spm_macros.svh"

package spm_pkg;

  // One data line of the scratchpad
  typedef logic [8*`SPM_BYTES-1:0] line_t;

  // One write-enable bit per byte lane
  typedef logic [`SPM_BYTES-1:0] be_t;

  // Word address local to a bank
  typedef logic [`SPM_BANK_AW-1:0] bank_addr_t;

  // Bank index taken from the low address bits
  typedef logic [`SPM_SEL_W-1:0] bank_sel_t;

  // Full word address, bank index in the low bits and the
  // local address above it
  typedef logic [`SPM_BANK_AW+`SPM_SEL_W-1:0] word_addr_t;

endpackage

//--- verilog/spm_bank.sv
`include "spm_macros.svh"

module spm_bank (
  input  logic                clk,

  input  logic                en_a,
  input  logic                ren_a,
  input  spm_pkg::be_t        we_a,
  input  spm_pkg::bank_addr_t addr_a,
  input  spm_pkg::line_t      din_a,
  output spm_pkg::line_t      dout_a,

  input  logic                en_b,
  input  logic                ren_b,
  input  spm_pkg::be_t        we_b,
  input  spm_pkg::bank_addr_t addr_b,
  input  spm_pkg::line_t      din_b,
  output spm_pkg::line_t      dout_b
);
  import spm_pkg::*;

  localparam int DEPTH = 2 ** `SPM_BANK_AW;

  line_t mem [DEPTH];
  line_t rd_a;  // Registered read data, port a
  line_t rd_b;  // Registered read data, port b

  // Port b goes first so a later port a write to the same byte wins
  always @(posedge clk) begin
    if (en_b) begin
      for (int i = 0; i < `SPM_BYTES; i++) begin
        if (we_b[i]) begin
          mem[addr_b][i*8 +: 8] <= din_b[i*8 +: 8];
        end
      end
    end
    if (en_a) begin
      for (int i = 0; i < `SPM_BYTES; i++) begin
        if (we_a[i]) begin
          mem[addr_a][i*8 +: 8] <= din_a[i*8 +: 8];
        end
      end
    end
  end

  // Reads see the contents from before this cycle's writes
  always_ff @(posedge clk) begin
    if (en_a && ren_a) begin
      rd_a <= mem[addr_a];
    end
    if (en_b && ren_b) begin
      rd_b <= mem[addr_b];
    end
  end

  assign dout_a = rd_a;
  assign dout_b = rd_b;

  // Scratchpad starts out all zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

endmodule

//--- verilog/spm_port_router.sv
`include "spm_macros.svh"

module spm_port_router (
  input  logic                      en,
  input  logic                      ren,
  input  spm_pkg::be_t              we,
  input  spm_pkg::word_addr_t       addr,
  input  spm_pkg::line_t            wdata,

  output logic [`SPM_NUM_BANKS-1:0] bank_en,
  output logic [`SPM_NUM_BANKS-1:0] bank_ren,
  output spm_pkg::bank_addr_t       bank_addr,
  output spm_pkg::be_t              bank_we,
  output spm_pkg::line_t            bank_wdata
);
  import spm_pkg::*;

  bank_sel_t                 sel;         // Addressed bank
  logic [`SPM_NUM_BANKS-1:0] sel_onehot;  // One bit per bank

  // Word interleave, low bits pick the bank
  assign sel       = addr[`SPM_SEL_W-1:0];
  assign bank_addr = addr[`SPM_SEL_W +: `SPM_BANK_AW];

  always_comb begin
    sel_onehot      = '0;
    sel_onehot[sel] = 1'b1;
  end

  // Only the addressed bank sees the strobes
  always_comb begin
    if (en) begin
      bank_en = sel_onehot;
    end else begin
      bank_en = '0;
    end
  end

  always_comb begin
    if (en && ren) begin
      bank_ren = sel_onehot;
    end else begin
      bank_ren = '0;
    end
  end

  // Byte enables and data go to every bank, qualified there by bank_en
  assign bank_we    = we;
  assign bank_wdata = wdata;

endmodule

//--- verilog/spm_read_merge.sv
`include "spm_macros.svh"

module spm_read_merge (
  input  logic               clk,
  input  logic               rst,

  input  logic               en,
  input  logic               ren,
  input  spm_pkg::bank_sel_t sel,

  input  spm_pkg::line_t     bank_dout [`SPM_NUM_BANKS],

  output spm_pkg::line_t     rdata,
  output logic               rvalid
);
  import spm_pkg::*;

  logic      rd_q;   // Read issued last cycle
  bank_sel_t sel_q;  // Bank that answers it

  // Registered alongside the bank's output register, so both line up
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= en && ren;
    end
  end

  // Select only moves on a read so rdata holds between reads
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= '0;
    end else if (en && ren) begin
      sel_q <= sel;
    end
  end

  assign rdata  = bank_dout[sel_q];  // Banks hold dout between reads
  assign rvalid = rd_q;

endmodule

//--- verilog/spm_top.sv
`include "spm_macros.svh"

module spm_top (
  input  logic                clk,
  input  logic                rst,

  // Core load/store port
  input  logic                a_en,
  input  logic                a_ren,
  input  spm_pkg::be_t        a_we,
  input  spm_pkg::word_addr_t a_addr,
  input  spm_pkg::line_t      a_wdata,
  output spm_pkg::line_t      a_rdata,
  output logic                a_rvalid,

  // DMA and init port
  input  logic                b_en,
  input  logic                b_ren,
  input  spm_pkg::be_t        b_we,
  input  spm_pkg::word_addr_t b_addr,
  input  spm_pkg::line_t      b_wdata,
  output spm_pkg::line_t      b_rdata,
  output logic                b_rvalid
);
  import spm_pkg::*;

  logic [`SPM_NUM_BANKS-1:0] bank_en_a;
  logic [`SPM_NUM_BANKS-1:0] bank_ren_a;
  bank_addr_t                bank_addr_a;
  be_t                       bank_we_a;
  line_t                     bank_wdata_a;

  logic [`SPM_NUM_BANKS-1:0] bank_en_b;
  logic [`SPM_NUM_BANKS-1:0] bank_ren_b;
  bank_addr_t                bank_addr_b;
  be_t                       bank_we_b;
  line_t                     bank_wdata_b;

  line_t dout_a [`SPM_NUM_BANKS];  // Per-bank read data, port a
  line_t dout_b [`SPM_NUM_BANKS];  // Per-bank read data, port b

  spm_port_router router_a_inst (
    .en        (a_en),
    .ren       (a_ren),
    .we        (a_we),
    .addr      (a_addr),
    .wdata     (a_wdata),
    .bank_en   (bank_en_a),
    .bank_ren  (bank_ren_a),
    .bank_addr (bank_addr_a),
    .bank_we   (bank_we_a),
    .bank_wdata(bank_wdata_a)
  );

  spm_port_router router_b_inst (
    .en        (b_en),
    .ren       (b_ren),
    .we        (b_we),
    .addr      (b_addr),
    .wdata     (b_wdata),
    .bank_en   (bank_en_b),
    .bank_ren  (bank_ren_b),
    .bank_addr (bank_addr_b),
    .bank_we   (bank_we_b),
    .bank_wdata(bank_wdata_b)
  );

  // Each bank has both ports, so a and b never stall on each other
  for (genvar i = 0; i < `SPM_NUM_BANKS; i++) begin : g_bank
    spm_bank bank_inst (
      .clk   (clk),
      .en_a  (bank_en_a[i]),
      .ren_a (bank_ren_a[i]),
      .we_a  (bank_we_a),
      .addr_a(bank_addr_a),
      .din_a (bank_wdata_a),
      .dout_a(dout_a[i]),
      .en_b  (bank_en_b[i]),
      .ren_b (bank_ren_b[i]),
      .we_b  (bank_we_b),
      .addr_b(bank_addr_b),
      .din_b (bank_wdata_b),
      .dout_b(dout_b[i])
    );
  end

  spm_read_merge merge_a_inst (
    .clk      (clk),
    .rst      (rst),
    .en       (a_en),
    .ren      (a_ren),
    .sel      (a_addr[`SPM_SEL_W-1:0]),  // Same bank decode as the router
    .bank_dout(dout_a),
    .rdata    (a_rdata),
    .rvalid   (a_rvalid)
  );

  spm_read_merge merge_b_inst (
    .clk      (clk),
    .rst      (rst),
    .en       (b_en),
    .ren      (b_ren),
    .sel      (b_addr[`SPM_SEL_W-1:0]),
    .bank_dout(dout_b),
    .rdata    (b_rdata),
    .rvalid   (b_rvalid)
  );

endmodule

//--- verif/spm_clk_gen.sv
module spm_clk_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 2;  // 4 ns period

  initial begin
    clk = 1'b0;
  end

  always begin
    #HALF_PERIOD clk = ~clk;
  end

endmodule

//--- verif/spm_asserts.sv
module spm_asserts (
  input logic clk,
  input logic rst,
  input logic a_en,
  input logic a_ren,
  input logic a_rvalid,
  input logic b_en,
  input logic b_ren,
  input logic b_rvalid
);
  timeunit 1ns;
  timeprecision 1ps;

  // A read answers in the next cycle and only then
  a_read_latency: assert property (
    @(posedge clk) disable iff (rst)
      a_rvalid == $past(a_en && a_ren && !rst)
  ) else $error("a_rvalid does not follow the port a read one cycle earlier");

  b_read_latency: assert property (
    @(posedge clk) disable iff (rst)
      b_rvalid == $past(b_en && b_ren && !rst)
  ) else $error("b_rvalid does not follow the port b read one cycle earlier");

  // From the second reset cycle on the valid flags are cleared
  a_reset_quiet: assert property (
    @(posedge clk) rst && $past(rst) |-> !a_rvalid
  ) else $error("a_rvalid high during reset");

  b_reset_quiet: assert property (
    @(posedge clk) rst && $past(rst) |-> !b_rvalid
  ) else $error("b_rvalid high during reset");

endmodule

//--- verif/spm_tb.sv
module spm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import spm_pkg::*;

  localparam int RST_CYCLES = 8;
  localparam int IDLE_LINES = 8;  // Random idle cycles after the file's lines

  // One cycle of requests and the outputs expected in that cycle
  typedef struct packed {
    logic       rst;
    logic       a_en;
    logic       a_ren;
    be_t        a_we;
    word_addr_t a_addr;
    line_t      a_wdata;
    logic       b_en;
    logic       b_ren;
    be_t        b_we;
    word_addr_t b_addr;
    line_t      b_wdata;
    logic       exp_a_rvalid;
    line_t      exp_a_rdata;
    logic       exp_b_rvalid;
    line_t      exp_b_rdata;
  } stim_t;

  logic       clk;
  logic       rst;
  logic       a_en;
  logic       a_ren;
  be_t        a_we;
  word_addr_t a_addr;
  line_t      a_wdata;
  line_t      a_rdata;
  logic       a_rvalid;
  logic       b_en;
  logic       b_ren;
  be_t        b_we;
  word_addr_t b_addr;
  line_t      b_wdata;
  line_t      b_rdata;
  logic       b_rvalid;

  stim_t  stim_q [$];
  integer seed;
  int     timeout_cycles = 1000;  // Reset once the stim length is known
  int     cycle_cnt = 0;

  spm_clk_gen clk_gen_inst (
    .clk(clk)
  );

  spm_top spm_top_inst (
    .clk     (clk),
    .rst     (rst),
    .a_en    (a_en),
    .a_ren   (a_ren),
    .a_we    (a_we),
    .a_addr  (a_addr),
    .a_wdata (a_wdata),
    .a_rdata (a_rdata),
    .a_rvalid(a_rvalid),
    .b_en    (b_en),
    .b_ren   (b_ren),
    .b_we    (b_we),
    .b_addr  (b_addr),
    .b_wdata (b_wdata),
    .b_rdata (b_rdata),
    .b_rvalid(b_rvalid)
  );

  bind spm_top spm_asserts asserts_inst (
    .clk     (clk),
    .rst     (rst),
    .a_en    (a_en),
    .a_ren   (a_ren),
    .a_rvalid(a_rvalid),
    .b_en    (b_en),
    .b_ren   (b_ren),
    .b_rvalid(b_rvalid)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h",
                         $time, name, got, exp));
    end
  endtask

  task automatic load_stim();
    int         fd;
    int         n;
    string      line_str;
    logic       f_rst, f_aen, f_aren, f_ben, f_bren, f_earv, f_ebrv;
    be_t        f_awe, f_bwe;
    word_addr_t f_aaddr, f_baddr;
    line_t      f_awdata, f_bwdata, f_eard, f_ebrd;
    fd = $fopen("verif/spm_stim.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open the stimulus file verif/spm_stim.txt");
    end
    while ($fgets(line_str, fd) != 0) begin
      if (line_str.getc(0) == "#") begin
        continue;  // Column description
      end
      n = $sscanf(line_str, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f_rst, f_aen, f_aren, f_awe, f_aaddr, f_awdata,
                  f_ben, f_bren, f_bwe, f_baddr, f_bwdata,
                  f_earv, f_eard, f_ebrv, f_ebrd);
      if (n <= 0) begin
        continue;  // Blank line
      end
      if (n != 15) begin
        fail_run("The stimulus file has a line without all 15 columns");
      end
      stim_q.push_back('{f_rst, f_aen, f_aren, f_awe, f_aaddr, f_awdata,
                         f_ben, f_bren, f_bwe, f_baddr, f_bwdata,
                         f_earv, f_eard, f_ebrv, f_ebrd});
    end
    $fclose(fd);
    if (stim_q.size() == 0) begin
      fail_run("The stimulus file holds no request lines");
    end
  endtask

  // Random bus noise that never raises en
  task automatic append_idle();
    stim_t       s;
    logic [31:0] rnd;
    for (int i = 0; i < IDLE_LINES; i++) begin
      s         = '0;
      s.a_wdata = $random(seed);
      s.b_wdata = $random(seed);
      rnd       = $random(seed);
      s.a_addr  = rnd[0 +: $bits(word_addr_t)];
      s.a_ren   = rnd[10];
      s.a_we    = rnd[12 +: $bits(be_t)];
      s.b_addr  = rnd[16 +: $bits(word_addr_t)];
      s.b_ren   = rnd[26];
      s.b_we    = rnd[28 +: $bits(be_t)];
      stim_q.push_back(s);
    end
  endtask

  task automatic drive(input stim_t s);
    rst     = s.rst;
    a_en    = s.a_en;
    a_ren   = s.a_ren;
    a_we    = s.a_we;
    a_addr  = s.a_addr;
    a_wdata = s.a_wdata;
    b_en    = s.b_en;
    b_ren   = s.b_ren;
    b_we    = s.b_we;
    b_addr  = s.b_addr;
    b_wdata = s.b_wdata;
  endtask

  // rdata is only meaningful while rvalid is high
  task automatic check_outputs(input stim_t s);
    check("a_rvalid", line_t'(a_rvalid), line_t'(s.exp_a_rvalid));
    if (s.exp_a_rvalid) begin
      check("a_rdata", a_rdata, s.exp_a_rdata);
    end
    check("b_rvalid", line_t'(b_rvalid), line_t'(s.exp_b_rvalid));
    if (s.exp_b_rvalid) begin
      check("b_rdata", b_rdata, s.exp_b_rdata);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > timeout_cycles) begin
      fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
                         timeout_cycles));
    end
  end

  initial begin
    seed    = 82524;
    rst     = 1'b1;
    a_en    = 1'b0;
    a_ren   = 1'b0;
    a_we    = '0;
    a_addr  = '0;
    a_wdata = '0;
    b_en    = 1'b0;
    b_ren   = 1'b0;
    b_we    = '0;
    b_addr  = '0;
    b_wdata = '0;
    load_stim();
    append_idle();
    timeout_cycles = stim_q.size() + RST_CYCLES + 20;
    repeat (RST_CYCLES) @(posedge clk);
    foreach (stim_q[i]) begin
      #1;
      drive(stim_q[i]);  // Also releases reset on the first line
      #2;                // Just before the next rising edge
      check_outputs(stim_q[i]);
      @(posedge clk);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verif/spm_stim.txt
# rst a_en a_ren a_we a_addr a_wdata b_en b_ren b_we b_addr b_wdata, then the expected
# a_rvalid a_rdata b_rvalid b_rdata of this cycle (the previous line's reads), all hex
0 1 1 0 010 00000000 1 1 0 021 00000000 0 00000000 0 00000000
0 1 1 0 3ff 00000000 1 1 0 102 00000000 1 00000000 1 00000000
0 0 0 0 000 00000000 0 0 0 000 00000000 1 00000000 1 00000000
0 0 0 0 000 00000000 0 0 0 000 00000000 0 00000000 0 00000000
0 1 0 f 040 11111111 0 0 0 000 00000000 0 00000000 0 00000000
0 1 0 f 041 22222222 0 0 0 000 00000000 0 00000000 0 00000000
0 1 0 f 042 33333333 0 0 0 000 00000000 0 00000000 0 00000000
0 1 0 f 043 44444444 0 0 0 000 00000000 0 00000000 0 00000000
0 1 1 0 040 00000000 1 1 0 043 00000000 0 00000000 0 00000000
0 1 1 0 041 00000000 1 1 0 042 00000000 1 11111111 1 44444444
0 1 1 0 042 00000000 1 1 0 041 00000000 1 22222222 1 33333333
0 1 1 0 043 00000000 1 1 0 040 00000000 1 33333333 1 22222222
0 0 0 0 000 00000000 0 0 0 000 00000000 1 44444444 1 11111111
0 1 0 5 040 aabbccdd 0 0 0 000 00000000 0 00000000 0 00000000
0 1 1 0 040 00000000 1 0 8 041 99000000 0 00000000 0 00000000
0 1 1 0 041 00000000 0 0 0 000 00000000 1 11bb11dd 0 00000000
0 0 0 0 000 00000000 0 0 0 000 00000000 1 99222222 0 00000000
0 1 1 f 042 5a5a5a5a 0 0 0 000 00000000 0 00000000 0 00000000
0 1 1 0 042 00000000 0 0 0 000 00000000 1 33333333 0 00000000
0 0 0 0 000 00000000 1 1 3 043 0000beef 1 5a5a5a5a 0 00000000
0 0 0 0 000 00000000 1 1 0 043 00000000 0 00000000 1 44444444
0 0 0 0 000 00000000 0 0 0 000 00000000 0 00000000 1 4444beef
0 1 0 3 044 a0a1a2a3 1 0 6 044 b0b1b2b3 0 00000000 0 00000000
0 1 1 0 044 00000000 1 1 0 044 00000000 0 00000000 0 00000000
0 1 1 0 040 00000000 1 1 0 041 00000000 1 00b1a2a3 1 00b1a2a3
0 1 1 0 042 00000000 1 1 0 042 00000000 1 11bb11dd 1 99222222
0 1 1 0 043 00000000 1 1 0 047 00000000 1 5a5a5a5a 1 5a5a5a5a
0 1 1 0 041 00000000 1 1 0 040 00000000 1 4444beef 1 00000000
0 0 0 0 000 00000000 0 0 0 000 00000000 1 99222222 1 11bb11dd
1 0 0 0 000 00000000 0 0 0 000 00000000 0 00000000 0 00000000
1 1 1 0 040 00000000 1 1 0 041 00000000 0 00000000 0 00000000
1 0 0 0 000 00000000 0 0 0 000 00000000 0 00000000 0 00000000
0 1 1 0 043 00000000 1 1 0 044 00000000 0 00000000 0 00000000
0 1 1 0 041 00000000 1 1 0 042 00000000 1 4444beef 1 00b1a2a3
0 0 0 0 000 00000000 0 0 0 000 00000000 1 99222222 1 5a5a5a5a
0 0 0 0 000 00000000 0 0 0 000 00000000 0 00000000 0 00000000

//--- tb.f
+incdir+include
verilog/spm_pkg.sv
verilog/spm_bank.sv
verilog/spm_port_router.sv
verilog/spm_read_merge.sv
verilog/spm_top.sv
verif/spm_clk_gen.sv
verif/spm_asserts.sv
verif/spm_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module spm_tb -f tb.f &&
  ./obj_dir/Vspm_tb ||
  { echo "Simulation did not complete cleanly" >&2; exit 1; }
